// File: logic/mandelPkg.sv
`default_nettype none

package mandelPkg;

  //////////////////////////////////////////////////
  // Frame and engine sizing
  //////////////////////////////////////////////////
  localparam int frameWidth    = 16;
  localparam int frameHeight   = 12;
  localparam int framePixels   = frameWidth * frameHeight;
  localparam int fracBits      = 32;  // Fraction part of a coordinate
  localparam int coordBits     = 36;  // 4 integer bits on top
  localparam int baseStepShift = 2;   // Quarter step at zoom 0
  localparam int numEngines    = 4;
  localparam int maxIter       = 63;

  //////////////////////////////////////////////////
  // Shared types
  //////////////////////////////////////////////////
  typedef logic signed [coordBits-1:0] coordWord;
  typedef logic [7:0] pixelAddr;                    // Row * frameWidth + column
  typedef logic [2:0] colorCode;
  typedef logic [4:0] zoomLevel;
  typedef logic [5:0] iterCount;
  typedef logic [numEngines-1:0] engineMask;        // One bit per engine
  typedef logic [$clog2(numEngines)-1:0] engineIndex;

  typedef enum logic {genIdle, genIssue} genState;
  typedef enum logic [1:0] {engIdle, engIterate, engReport} engState;

  // Round-robin search
  // First requester after the last grant, or the last grant itself if none
  function automatic engineIndex rrPick(engineMask req, engineIndex last);
    engineIndex pick;
    engineIndex cand;
    pick = last;
    for (int i = numEngines; i >= 1; i--) begin  // Nearest candidate wins
      cand = engineIndex'((int'(last) + i) % numEngines);
      if (req[cand]) pick = cand;
    end
    return pick;
  endfunction

endpackage

`default_nettype wire

// File: logic/pixelCoordGen.sv
`timescale 1ns/1ps
`default_nettype none

module pixelCoordGen (
  input  logic                CLOCK_50,
  input  logic                reset,
  input  logic                draw,
  input  mandelPkg::zoomLevel zoom,
  input  mandelPkg::coordWord upperLeftX,
  input  mandelPkg::coordWord upperLeftY,
  input  logic                busy,
  input  logic                coordReady,
  output logic                frameStart,
  output logic                coordValid,
  output mandelPkg::coordWord coordX,
  output mandelPkg::coordWord coordY,
  output mandelPkg::pixelAddr coordAddr
);

  typedef logic [$clog2(mandelPkg::frameWidth)-1:0]  colIdx;
  typedef logic [$clog2(mandelPkg::frameHeight)-1:0] rowIdx;

  mandelPkg::genState  state;
  mandelPkg::coordWord viewX;  // Left edge, reloaded every row
  mandelPkg::coordWord step;
  colIdx col;
  rowIdx row;
  logic  accept;
  logic  transfer;
  logic  lastCol;

  assign accept     = draw && (state == mandelPkg::genIdle) && !busy;
  assign coordValid = (state == mandelPkg::genIssue);
  assign transfer   = coordValid && coordReady;
  assign lastCol    = (col == colIdx'(mandelPkg::frameWidth - 1));
  assign coordAddr  = mandelPkg::pixelAddr'(row) * mandelPkg::pixelAddr'(mandelPkg::frameWidth)
                      + mandelPkg::pixelAddr'(col);  // Raster order

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////
  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      state      <= mandelPkg::genIdle;
      frameStart <= 1'b0;
      col        <= '0;
      row        <= '0;
    end else begin
      frameStart <= accept;  // One-cycle pulse, lines up with first coordValid
      case (state)
        mandelPkg::genIdle: begin
          if (accept) begin
            state <= mandelPkg::genIssue;
            col   <= '0;
            row   <= '0;
          end
        end
        mandelPkg::genIssue: begin
          if (transfer) begin
            if (lastCol) begin
              col <= '0;
              row <= row + 1'b1;
              // Bottom-right pixel handed off
              if (row == rowIdx'(mandelPkg::frameHeight - 1)) state <= mandelPkg::genIdle;
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        default: state <= mandelPkg::genIdle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // View and coordinate stepping
  //////////////////////////////////////////////////
  always_ff @(posedge CLOCK_50) begin
    if (accept) begin
      viewX  <= upperLeftX;
      coordX <= upperLeftX;
      coordY <= upperLeftY;
      // One shifted right by base shift plus zoom
      step   <= (mandelPkg::coordWord'(1) <<< mandelPkg::fracBits)
                >>> (mandelPkg::baseStepShift + zoom);
    end else if (transfer) begin
      if (lastCol) begin
        coordX <= viewX;          // Back to left edge
        coordY <= coordY - step;  // Imaginary part falls going down
      end else begin
        coordX <= coordX + step;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/workDispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module workDispatcher (
  input  logic                 CLOCK_50,
  input  logic                 reset,
  input  logic                 coordValid,
  input  mandelPkg::engineMask engineIdle,
  output logic                 coordReady,
  output mandelPkg::engineMask jobStart
);

  mandelPkg::engineIndex lastGrant;  // Engine that got the previous pixel
  mandelPkg::engineIndex pick;
  logic                  grant;

  // Any idle engine can take a pixel
  always_comb begin
    pick       = mandelPkg::rrPick(engineIdle, lastGrant);
    coordReady = |engineIdle;
    grant      = coordValid && coordReady;
    jobStart   = grant ? (mandelPkg::engineMask'(1) << pick) : '0;  // One-hot
  end

  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      // First grant lands on engine 0
      lastGrant <= mandelPkg::engineIndex'(mandelPkg::numEngines - 1);
    end else if (grant) begin
      lastGrant <= pick;
    end
  end

endmodule

`default_nettype wire

// File: logic/escapeIterator.sv
`timescale 1ns/1ps
`default_nettype none

module escapeIterator (
  input  logic                CLOCK_50,
  input  logic                reset,
  input  logic                jobStart,
  input  mandelPkg::coordWord jobX,
  input  mandelPkg::coordWord jobY,
  input  mandelPkg::pixelAddr jobAddr,
  input  logic                resultTaken,
  output logic                engineIdle,
  output logic                resultValid,
  output mandelPkg::colorCode resultColor,
  output mandelPkg::pixelAddr resultAddr
);

  typedef logic signed [2*mandelPkg::coordBits-1:0] wideWord;

  mandelPkg::engState  state;
  mandelPkg::coordWord cX;
  mandelPkg::coordWord cY;
  mandelPkg::coordWord zX;
  mandelPkg::coordWord zY;
  mandelPkg::iterCount count;

  wideWord prodXX;  // Exact products
  wideWord prodYY;
  wideWord prodXY;
  wideWord magSq;   // Kept wide so it never wraps
  mandelPkg::coordWord sqX;
  mandelPkg::coordWord sqY;
  mandelPkg::coordWord crossXY;
  logic escaped;
  logic atLimit;

  //////////////////////////////////////////////////
  // Escape test and next z
  //////////////////////////////////////////////////
  always_comb begin
    prodXX  = wideWord'(zX) * wideWord'(zX);
    prodYY  = wideWord'(zY) * wideWord'(zY);
    prodXY  = wideWord'(zX) * wideWord'(zY);
    magSq   = (prodXX >>> mandelPkg::fracBits) + (prodYY >>> mandelPkg::fracBits);
    escaped = (magSq >= (wideWord'(4) <<< mandelPkg::fracBits));  // |z|^2 >= 4
    atLimit = (count == mandelPkg::iterCount'(mandelPkg::maxIter));
    sqX     = mandelPkg::coordWord'(prodXX >>> mandelPkg::fracBits);  // Truncated
    sqY     = mandelPkg::coordWord'(prodYY >>> mandelPkg::fracBits);
    crossXY = mandelPkg::coordWord'(prodXY >>> mandelPkg::fracBits);
  end

  assign engineIdle  = (state == mandelPkg::engIdle);
  assign resultValid = (state == mandelPkg::engReport);

  //////////////////////////////////////////////////
  // Engine FSM
  //////////////////////////////////////////////////
  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      state <= mandelPkg::engIdle;
    end else begin
      case (state)
        mandelPkg::engIdle:    if (jobStart) state <= mandelPkg::engIterate;
        mandelPkg::engIterate: if (escaped || atLimit) state <= mandelPkg::engReport;
        mandelPkg::engReport:  if (resultTaken) state <= mandelPkg::engIdle;  // Held until taken
        default:               state <= mandelPkg::engIdle;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge CLOCK_50) begin
    case (state)
      mandelPkg::engIdle: begin
        if (jobStart) begin  // Capture c and address
          cX         <= jobX;
          cY         <= jobY;
          resultAddr <= jobAddr;
          zX         <= '0;
          zY         <= '0;
          count      <= '0;
        end
      end
      mandelPkg::engIterate: begin
        if (escaped) begin
          resultColor <= mandelPkg::colorCode'(count[2:0]);  // Low count bits
        end else if (atLimit) begin
          resultColor <= '0;  // Inside the set
        end else begin
          zX    <= sqX - sqY + cX;
          zY    <= (crossXY <<< 1) + cY;  // 2xy from truncated product
          count <= count + 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/frameWriteArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module frameWriteArbiter (
  input  logic                                          CLOCK_50,
  input  logic                                          reset,
  input  logic                                          frameStart,
  input  mandelPkg::engineMask                          resultValid,
  input  mandelPkg::colorCode [mandelPkg::numEngines-1:0] resultColor,
  input  mandelPkg::pixelAddr [mandelPkg::numEngines-1:0] resultAddr,
  output mandelPkg::engineMask                          resultTaken,
  output logic                                          pixelWrite,
  output mandelPkg::pixelAddr                           pixelWriteAddr,
  output mandelPkg::colorCode                           pixelWriteColor,
  output logic                                          busy,
  output logic                                          renderDone
);

  typedef logic [$clog2(mandelPkg::framePixels+1)-1:0] writeCnt;

  mandelPkg::engineIndex lastGrant;
  mandelPkg::engineIndex pick;
  writeCnt               writeCount;  // Pixels written this frame

  //////////////////////////////////////////////////
  // Grant and write mux
  //////////////////////////////////////////////////
  always_comb begin
    pick            = mandelPkg::rrPick(resultValid, lastGrant);
    pixelWrite      = resultValid[pick];  // Only false when nothing is held
    resultTaken     = pixelWrite ? (mandelPkg::engineMask'(1) << pick) : '0;
    pixelWriteAddr  = resultAddr[pick];
    pixelWriteColor = resultColor[pick];
  end

  //////////////////////////////////////////////////
  // Frame progress
  //////////////////////////////////////////////////
  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      busy       <= 1'b0;
      renderDone <= 1'b0;
      writeCount <= '0;
      lastGrant  <= mandelPkg::engineIndex'(mandelPkg::numEngines - 1);
    end else begin
      if (frameStart) begin  // New render
        busy       <= 1'b1;
        renderDone <= 1'b0;
        writeCount <= '0;
      end else if (pixelWrite && busy) begin
        writeCount <= writeCount + 1'b1;
        if (writeCount == writeCnt'(mandelPkg::framePixels - 1)) begin  // Final pixel
          busy       <= 1'b0;
          renderDone <= 1'b1;
        end
      end
      if (pixelWrite) lastGrant <= pick;
    end
  end

endmodule

`default_nettype wire

// File: logic/frameBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module frameBuffer (
  input  logic                CLOCK_50,
  input  logic                pixelWrite,
  input  mandelPkg::pixelAddr pixelWriteAddr,
  input  mandelPkg::colorCode pixelWriteColor,
  input  mandelPkg::pixelAddr readAddr,
  output mandelPkg::colorCode readColor
);

  mandelPkg::colorCode mem [mandelPkg::framePixels];  // One colour per pixel

  always_ff @(posedge CLOCK_50) begin
    if (pixelWrite) mem[pixelWriteAddr] <= pixelWriteColor;
    readColor <= mem[readAddr];  // Registered read, one cycle
  end

endmodule

`default_nettype wire

// File: logic/mandelRenderer.sv
`timescale 1ns/1ps
`default_nettype none

module mandelRenderer (
  input  logic                CLOCK_50,
  input  logic                reset,
  input  logic                draw,
  input  mandelPkg::zoomLevel zoom,
  input  mandelPkg::coordWord upperLeftX,
  input  mandelPkg::coordWord upperLeftY,
  input  mandelPkg::pixelAddr readAddr,
  output logic                busy,
  output logic                renderDone,
  output mandelPkg::colorCode readColor
);

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////
  logic                frameStart;
  logic                coordValid;
  logic                coordReady;
  mandelPkg::coordWord coordX;     // Shared by all engines
  mandelPkg::coordWord coordY;
  mandelPkg::pixelAddr coordAddr;

  mandelPkg::engineMask engineIdle;
  mandelPkg::engineMask jobStart;
  mandelPkg::engineMask resultValid;
  mandelPkg::engineMask resultTaken;
  mandelPkg::colorCode [mandelPkg::numEngines-1:0] resultColor;
  mandelPkg::pixelAddr [mandelPkg::numEngines-1:0] resultAddr;

  logic                pixelWrite;
  mandelPkg::pixelAddr pixelWriteAddr;
  mandelPkg::colorCode pixelWriteColor;

  pixelCoordGen u_coordGen (
    .CLOCK_50   (CLOCK_50),
    .reset      (reset),
    .draw       (draw),
    .zoom       (zoom),
    .upperLeftX (upperLeftX),
    .upperLeftY (upperLeftY),
    .busy       (busy),        // Blocks a new request mid-render
    .coordReady (coordReady),
    .frameStart (frameStart),
    .coordValid (coordValid),
    .coordX     (coordX),
    .coordY     (coordY),
    .coordAddr  (coordAddr)
  );

  workDispatcher u_dispatch (
    .CLOCK_50   (CLOCK_50),
    .reset      (reset),
    .coordValid (coordValid),
    .engineIdle (engineIdle),
    .coordReady (coordReady),
    .jobStart   (jobStart)
  );

  // Escape-time engines
  for (genvar g = 0; g < mandelPkg::numEngines; g++) begin : g_engine
    escapeIterator u_engine (
      .CLOCK_50    (CLOCK_50),
      .reset       (reset),
      .jobStart    (jobStart[g]),
      .jobX        (coordX),
      .jobY        (coordY),
      .jobAddr     (coordAddr),
      .resultTaken (resultTaken[g]),
      .engineIdle  (engineIdle[g]),
      .resultValid (resultValid[g]),
      .resultColor (resultColor[g]),
      .resultAddr  (resultAddr[g])
    );
  end

  frameWriteArbiter u_writeArb (
    .CLOCK_50        (CLOCK_50),
    .reset           (reset),
    .frameStart      (frameStart),
    .resultValid     (resultValid),
    .resultColor     (resultColor),
    .resultAddr      (resultAddr),
    .resultTaken     (resultTaken),
    .pixelWrite      (pixelWrite),
    .pixelWriteAddr  (pixelWriteAddr),
    .pixelWriteColor (pixelWriteColor),
    .busy            (busy),
    .renderDone      (renderDone)
  );

  frameBuffer u_frameBuf (
    .CLOCK_50        (CLOCK_50),
    .pixelWrite      (pixelWrite),
    .pixelWriteAddr  (pixelWriteAddr),
    .pixelWriteColor (pixelWriteColor),
    .readAddr        (readAddr),
    .readColor       (readColor)
  );

endmodule

`default_nettype wire

// File: dv/mandelRenderer_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mandelRendererBind (
  input logic                 CLOCK_50,
  input logic                 reset,
  input mandelPkg::engineMask jobStart,
  input mandelPkg::engineMask engineIdle,
  input mandelPkg::engineMask resultTaken,
  input logic                 pixelWrite,
  input mandelPkg::pixelAddr  pixelWriteAddr,
  input logic                 busy,
  input logic                 renderDone
);

  // Failure tallies, one per property
  int takeFails = 0;
  int jobFails = 0;
  int addrFails = 0;
  int statusFails = 0;
  int assertFails;

  assign assertFails = takeFails + jobFails + addrFails + statusFails;

  //////////////////////////////////////////////////
  // Handshake and status properties
  //////////////////////////////////////////////////
  takeOneHot: assert property (@(posedge CLOCK_50) disable iff (reset)
    $onehot0(resultTaken))
    else begin
      takeFails = takeFails + 1;
      $error("resultTaken grants more than one engine");
    end

  // Dispatcher only targets idle engines
  jobToIdle: assert property (@(posedge CLOCK_50) disable iff (reset)
    (jobStart & ~engineIdle) == '0)
    else begin
      jobFails = jobFails + 1;
      $error("jobStart targets a busy engine");
    end

  writeInFrame: assert property (@(posedge CLOCK_50) disable iff (reset)
    pixelWrite |-> (int'(pixelWriteAddr) < mandelPkg::framePixels))
    else begin
      addrFails = addrFails + 1;
      $error("pixelWriteAddr outside the frame");
    end

  statusExclusive: assert property (@(posedge CLOCK_50) disable iff (reset)
    !(busy && renderDone))  // Never both
    else begin
      statusFails = statusFails + 1;
      $error("busy and renderDone high together");
    end

endmodule

bind mandelRenderer mandelRendererBind u_asserts (
  .CLOCK_50       (CLOCK_50),
  .reset          (reset),
  .jobStart       (jobStart),
  .engineIdle     (engineIdle),
  .resultTaken    (resultTaken),
  .pixelWrite     (pixelWrite),
  .pixelWriteAddr (pixelWriteAddr),
  .busy           (busy),
  .renderDone     (renderDone)
);

`default_nettype wire

// File: dv/mandelRendererTb.sv
`timescale 1ns/1ps
`default_nettype none

module mandelRendererTb;

  typedef logic signed [2*mandelPkg::coordBits-1:0] wideWord;  // Exact products

  typedef struct {
    string               name;
    mandelPkg::zoomLevel zoom;
    mandelPkg::coordWord ulX;
    mandelPkg::coordWord ulY;
    bit                  disturb;   // Second draw while busy
  } testRow;

  localparam int numTests = 6;
  localparam int watchdogCycles = numTests * mandelPkg::framePixels * (mandelPkg::maxIter + 6)
                                  + numTests * (mandelPkg::framePixels + 2) + 2000;

  logic                CLOCK_50 = 1'b0;
  logic                reset;
  logic                draw;
  mandelPkg::zoomLevel zoom;
  mandelPkg::coordWord upperLeftX;
  mandelPkg::coordWord upperLeftY;
  mandelPkg::pixelAddr readAddr;
  logic                busy;
  logic                renderDone;
  mandelPkg::colorCode readColor;

  testRow      tests [numTests];
  logic [15:0] lfsrState;
  int          errorCount = 0;
  int          testsFailed = 0;
  logic        doneSeen = 1'b0;
  int          doneRises = 0;    // Rising edges of renderDone so far

  mandelRenderer u_dut (
    .CLOCK_50   (CLOCK_50),
    .reset      (reset),
    .draw       (draw),
    .zoom       (zoom),
    .upperLeftX (upperLeftX),
    .upperLeftY (upperLeftY),
    .readAddr   (readAddr),
    .busy       (busy),
    .renderDone (renderDone),
    .readColor  (readColor)
  );

  always #5 CLOCK_50 = ~CLOCK_50;  // 10 ns period

  always @(posedge CLOCK_50) begin
    doneSeen <= renderDone;
    if (renderDone && !doneSeen) doneRises <= doneRises + 1;
  end

  //////////////////////////////////////////////////
  // Helpers and reference model
  //////////////////////////////////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[30:0], lfsrStep()};  // One step per bit
    return r;
  endfunction

  // num / den as a fixed-point coordinate
  function automatic mandelPkg::coordWord fixQ(input int num, input int den);
    wideWord w;
    w = (wideWord'(num) <<< mandelPkg::fracBits) / wideWord'(den);
    return mandelPkg::coordWord'(w);
  endfunction

  function automatic mandelPkg::colorCode expectColor(input mandelPkg::zoomLevel z,
      input mandelPkg::coordWord ulX, input mandelPkg::coordWord ulY, input int px, input int py);
    mandelPkg::coordWord step;
    mandelPkg::coordWord cx;
    mandelPkg::coordWord cy;
    mandelPkg::coordWord zx;
    mandelPkg::coordWord zy;
    mandelPkg::coordWord crossTerm;
    wideWord xx;
    wideWord yy;
    wideWord xy;
    wideWord four;
    step = (mandelPkg::coordWord'(1) <<< mandelPkg::fracBits)
           >>> (mandelPkg::baseStepShift + int'(z));
    cx   = ulX + mandelPkg::coordWord'(px) * step;
    cy   = ulY - mandelPkg::coordWord'(py) * step;  // Imaginary axis points up
    four = wideWord'(4) <<< mandelPkg::fracBits;
    zx   = '0;
    zy   = '0;
    for (int count = 0; count <= mandelPkg::maxIter; count++) begin
      xx = wideWord'(zx) * wideWord'(zx);
      yy = wideWord'(zy) * wideWord'(zy);
      xy = wideWord'(zx) * wideWord'(zy);
      if ((xx >>> mandelPkg::fracBits) + (yy >>> mandelPkg::fracBits) >= four)
        return mandelPkg::colorCode'(count % 8);  // Escaped
      if (count == mandelPkg::maxIter) return '0;  // Inside
      crossTerm = mandelPkg::coordWord'(xy >>> mandelPkg::fracBits);
      zx = mandelPkg::coordWord'(xx >>> mandelPkg::fracBits)
           - mandelPkg::coordWord'(yy >>> mandelPkg::fracBits) + cx;
      zy = crossTerm + crossTerm + cy;  // 2xy + cy
    end
    return '0;
  endfunction

  task automatic setRow(input int idx, input string name, input mandelPkg::zoomLevel z,
      input mandelPkg::coordWord x, input mandelPkg::coordWord y, input bit disturb);
    tests[idx].name    = name;
    tests[idx].zoom    = z;
    tests[idx].ulX     = x;
    tests[idx].ulY     = y;
    tests[idx].disturb = disturb;
  endtask

  task automatic buildTests();
    setRow(0, "fullView", 5'd0, fixQ(-2, 1), fixQ(3, 2), 1'b0);
    setRow(1, "zoom2", 5'd2, fixQ(-5, 4), fixQ(3, 8), 1'b0);
    // Near the boundary with jittered low fraction bits
    setRow(2, "zoom4Jitter", 5'd4,
           fixQ(-7, 8) + mandelPkg::coordWord'(randomBits(12)),
           fixQ(5, 16) + mandelPkg::coordWord'(randomBits(12)), 1'b0);
    setRow(3, "disturbedDraw", 5'd0, fixQ(-2, 1), fixQ(3, 2), 1'b1);
    setRow(4, "backToBackA", 5'd1, fixQ(-2, 1), fixQ(3, 4), 1'b0);
    setRow(5, "backToBackB", 5'd3, fixQ(-3, 4), fixQ(1, 4), 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Test sequences
  //////////////////////////////////////////////////
  task automatic checkResetIdle();
    int bad;
    bad = 0;
    repeat (20) begin  // Quiet until first draw
      @(negedge CLOCK_50);
      if (busy !== 1'b0 || renderDone !== 1'b0) begin
        $display("mismatch resetIdle busy/renderDone: expected 0/0, actual %b/%b",
                 busy, renderDone);
        bad++;
      end
    end
    errorCount += bad;
    if (bad != 0) testsFailed++;
    $display("test resetIdle: %s, %0d errors", (bad == 0) ? "ok" : "failed", bad);
  endtask

  task automatic runTest(input int idx);
    testRow              t;
    mandelPkg::colorCode expected [mandelPkg::framePixels];
    int                  bad;
    int                  risesBefore;
    int                  delay;
    t   = tests[idx];
    bad = 0;
    for (int a = 0; a < mandelPkg::framePixels; a++)
      expected[a] = expectColor(t.zoom, t.ulX, t.ulY, a % mandelPkg::frameWidth,
                                a / mandelPkg::frameWidth);
    risesBefore = doneRises;

    @(negedge CLOCK_50);
    zoom       = t.zoom;
    upperLeftX = t.ulX;
    upperLeftY = t.ulY;
    draw       = 1'b1;
    @(negedge CLOCK_50);
    draw = 1'b0;
    while (!busy) @(negedge CLOCK_50);  // Old renderDone clears here

    if (t.disturb) begin
      delay = 4 + int'(randomBits(5));
      repeat (delay) @(negedge CLOCK_50);
      if (!busy) begin
        $display("busy dropped before the second draw in test %s", t.name);
        bad++;
      end
      zoom       = 5'd3;  // Different view that must be ignored
      upperLeftX = fixQ(-1, 2);
      upperLeftY = fixQ(1, 2);
      draw       = 1'b1;
      @(negedge CLOCK_50);
      draw = 1'b0;
    end

    while (!renderDone) @(negedge CLOCK_50);

    // Read back whole frame
    for (int a = 0; a < mandelPkg::framePixels; a++) begin
      readAddr = mandelPkg::pixelAddr'(a);
      @(negedge CLOCK_50);
      if (readColor !== expected[a]) begin
        $display("mismatch %s addr %0d: expected %0d, actual %0d",
                 t.name, a, expected[a], readColor);
        bad++;
      end
    end

    if (doneRises - risesBefore != 1) begin
      $display("mismatch %s renderDone rises: expected 1, actual %0d",
               t.name, doneRises - risesBefore);
      bad++;
    end
    errorCount += bad;
    if (bad != 0) testsFailed++;
    $display("test %s: %s, %0d errors", t.name, (bad == 0) ? "ok" : "failed", bad);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    reset      = 1'b1;
    draw       = 1'b0;
    zoom       = '0;
    upperLeftX = '0;
    upperLeftY = '0;
    readAddr   = '0;
    lfsrState  = 16'd30;  // Seed
    buildTests();
    repeat (4) @(negedge CLOCK_50);
    reset = 1'b0;

    checkResetIdle();
    for (int i = 0; i < numTests; i++) runTest(i);

    if (u_dut.u_asserts.assertFails != 0) begin
      $display("assertions failed %0d times", u_dut.u_asserts.assertFails);
      errorCount++;
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             numTests + 1, numTests + 1 - testsFailed, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdogCycles * 10);
    $display("the render never finished within %0d cycles", watchdogCycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/mandelPkg.sv
logic/pixelCoordGen.sv
logic/workDispatcher.sv
logic/escapeIterator.sv
logic/frameWriteArbiter.sv
logic/frameBuffer.sv
logic/mandelRenderer.sv
dv/mandelRenderer_asserts.sv
dv/mandelRendererTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mandelRendererTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
